//--- fxp_pkg.sv
////////////////////////////////////////////////////////////
// Signed 8.8 fixed-point number format shared by the engine,
// the multipliers and the register block.
////////////////////////////////////////////////////////////
package fxp_pkg;

    parameter int INTEGER_PART_WIDTH    = 8;
    parameter int FRACTIONAL_PART_WIDTH = 8;
    parameter int NUMBER_WIDTH          = INTEGER_PART_WIDTH + FRACTIONAL_PART_WIDTH;

    // The value 1.0.
    parameter logic signed [NUMBER_WIDTH-1:0] FXP_ONE = 16'sh0100;

    typedef struct packed {
        logic [INTEGER_PART_WIDTH-1:0]    int_part;
        logic [FRACTIONAL_PART_WIDTH-1:0] frac_part;
    } fxp_parts_t;

    // One word, seen either as a signed number or split at the binary point.
    typedef union packed {
        logic signed [NUMBER_WIDTH-1:0] raw;
        fxp_parts_t                     parts;
    } fxp_word_t;

endpackage

//--- axil_regs_pkg.sv
////////////////////////////////////////////////////////////
// AXI4-Lite register map of the power unit: offsets,
// control and status bits, and response codes.
////////////////////////////////////////////////////////////
package axil_regs_pkg;

    parameter int ADDR_WIDTH = 5;
    parameter int DATA_WIDTH = 32;

    parameter logic [ADDR_WIDTH-1:0] REG_CTRL      = 5'h00;
    parameter logic [ADDR_WIDTH-1:0] REG_STATUS    = 5'h04;
    parameter logic [ADDR_WIDTH-1:0] REG_OPERAND_A = 5'h08;
    parameter logic [ADDR_WIDTH-1:0] REG_OPERAND_B = 5'h0C;
    parameter logic [ADDR_WIDTH-1:0] REG_RESULT    = 5'h10;

    // Writing a one here starts the engine.
    parameter int CTRL_START_BIT = 0;

    parameter int STATUS_BUSY_BIT = 0;
    parameter int STATUS_DONE_BIT = 1;

    parameter logic [1:0] RESP_OKAY   = 2'b00;
    parameter logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- fixed_point_mul.sv
////////////////////////////////////////////////////////////
// Sequential shift-add signed 8.8 multiplier. Pulse start
// while done is high, then wait for done to return.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fixed_point_mul #(
    parameter int BITS_PER_CYCLE = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    output logic               done,
    input  fxp_pkg::fxp_word_t a,
    input  fxp_pkg::fxp_word_t b,
    output fxp_pkg::fxp_word_t result
);

    localparam int NW        = fxp_pkg::NUMBER_WIDTH;
    localparam int FW        = fxp_pkg::FRACTIONAL_PART_WIDTH;
    localparam int STEPS     = NW / BITS_PER_CYCLE;
    localparam int CNT_WIDTH = $clog2(STEPS + 1);
    localparam int ACC_WIDTH = 2 * NW;

    logic [NW-1:0]               a_mag;
    logic [NW-1:0]               b_mag;
    logic [ACC_WIDTH-1:0]        mcand;
    logic [NW-1:0]               mplier;
    logic [ACC_WIDTH-1:0]        acc;
    logic [ACC_WIDTH-1:0]        partial;
    logic [ACC_WIDTH-1:0]        acc_next;
    logic signed [ACC_WIDTH-1:0] product;
    logic                        neg;
    logic [CNT_WIDTH-1:0]        count;

    assign a_mag = a.raw[NW-1] ? -a.raw : a.raw;
    assign b_mag = b.raw[NW-1] ? -b.raw : b.raw;

    // Partial products for the multiplier bits consumed this cycle.
    always_comb begin
        partial = '0;
        for (int i = 0; i < BITS_PER_CYCLE; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
    end

    assign acc_next = acc + partial;
    assign product  = neg ? -$signed(acc_next) : $signed(acc_next);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done  <= 1'b1;
            count <= '0;
        end else if (done) begin
            if (start) begin
                done  <= 1'b0;
                count <= CNT_WIDTH'(STEPS);
            end
        end else begin
            count <= count - 1'b1;
            if (count == CNT_WIDTH'(1)) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done && start) begin
            mcand  <= {{(ACC_WIDTH - NW){1'b0}}, a_mag};
            mplier <= b_mag;
            acc    <= '0;
            neg    <= a.raw[NW-1] ^ b.raw[NW-1];
        end else if (!done) begin
            mcand  <= mcand << BITS_PER_CYCLE;
            mplier <= mplier >> BITS_PER_CYCLE;
            acc    <= acc_next;
            // Arithmetic shift by the fraction width, truncated to one word.
            if (count == CNT_WIDTH'(1)) begin
                result.raw <= product[FW +: NW];
            end
        end
    end

endmodule

//--- fixed_point_pow.sv
////////////////////////////////////////////////////////////
// Raises a to the integer part of b by square-and-multiply.
// Pulse start while done is high; result is valid at done.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fixed_point_pow #(
    parameter int BITS_PER_CYCLE = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    output logic               done,
    input  fxp_pkg::fxp_word_t a,
    input  fxp_pkg::fxp_word_t b,
    output fxp_pkg::fxp_word_t result
);

    localparam int IW = fxp_pkg::INTEGER_PART_WIDTH;

    localparam logic [1:0] S_READY      = 2'd0;
    localparam logic [1:0] S_CHECK_ZERO = 2'd1;
    localparam logic [1:0] S_START_MUL  = 2'd2;
    localparam logic [1:0] S_WAIT_MUL   = 2'd3;

    logic [1:0]         state;
    fxp_pkg::fxp_word_t value;
    logic [IW-1:0]      power;
    logic               res_used;
    logic               mul_finished;

    logic               value_mul_start;
    logic               value_mul_done;
    fxp_pkg::fxp_word_t value_mul_result;
    logic               result_mul_start;
    logic               result_mul_done;
    fxp_pkg::fxp_word_t result_mul_result;

    assign done             = (state == S_READY);
    assign value_mul_start  = (state == S_START_MUL);
    assign result_mul_start = (state == S_START_MUL) && power[0];

    // The result multiplier only counts when it was started this step.
    assign mul_finished = value_mul_done && (!res_used || result_mul_done);

    fixed_point_mul #(
        .BITS_PER_CYCLE (BITS_PER_CYCLE)
    ) value_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (value_mul_start),
        .done   (value_mul_done),
        .a      (value),
        .b      (value),
        .result (value_mul_result)
    );

    fixed_point_mul #(
        .BITS_PER_CYCLE (BITS_PER_CYCLE)
    ) result_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (result_mul_start),
        .done   (result_mul_done),
        .a      (result),
        .b      (value),
        .result (result_mul_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_READY;
            res_used   <= 1'b0;
            result.raw <= '0;
        end else begin
            case (state)
                S_READY: begin
                    if (start) begin
                        state      <= S_CHECK_ZERO;
                        result.raw <= fxp_pkg::FXP_ONE;
                    end
                end
                S_CHECK_ZERO: begin
                    state <= (power == '0) ? S_READY : S_START_MUL;
                end
                S_START_MUL: begin
                    res_used <= power[0];
                    state    <= S_WAIT_MUL;
                end
                default: begin
                    if (mul_finished) begin
                        if (res_used) begin
                            result <= result_mul_result;
                        end
                        state <= (power == '0) ? S_READY : S_START_MUL;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_READY && start) begin
            value.raw <= a.raw;
            power     <= b.parts.int_part;
        end else if (state == S_START_MUL) begin
            power <= power >> 1;
        end else if (state == S_WAIT_MUL && mul_finished) begin
            value <= value_mul_result;
        end
    end

endmodule

//--- pow_axil_regs.sv
////////////////////////////////////////////////////////////
// AXI4-Lite slave holding operands, control, status and the
// result of the power engine.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pow_axil_regs (
    input  logic                                 clk,
    input  logic                                 rst_n,

    input  logic [axil_regs_pkg::ADDR_WIDTH-1:0]   awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [axil_regs_pkg::DATA_WIDTH-1:0]   wdata,
    input  logic [axil_regs_pkg::DATA_WIDTH/8-1:0] wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    output logic [1:0]                             bresp,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  logic [axil_regs_pkg::ADDR_WIDTH-1:0]   araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic [axil_regs_pkg::DATA_WIDTH-1:0]   rdata,
    output logic [1:0]                             rresp,
    output logic                                   rvalid,
    input  logic                                   rready,

    output logic                                 start,
    output fxp_pkg::fxp_word_t                   a,
    output fxp_pkg::fxp_word_t                   b,
    input  logic                                 done,
    input  fxp_pkg::fxp_word_t                   result
);

    localparam int DW  = axil_regs_pkg::DATA_WIDTH;
    localparam int EXT = DW - fxp_pkg::NUMBER_WIDTH;

    logic          wr_accept;
    logic          rd_accept;
    logic          start_write;
    logic          done_prev;
    logic          done_sticky;
    logic [1:0]    wr_resp;
    logic [DW-1:0] rd_data;
    logic [1:0]    rd_resp;

    assign wr_accept = awvalid && wvalid && awready && wready;
    assign rd_accept = arvalid && arready;
    assign arready   = !rvalid;

    // Strobes are not decoded, every accepted write is a full word.
    assign start_write = wr_accept && (awaddr == axil_regs_pkg::REG_CTRL)
                         && wdata[axil_regs_pkg::CTRL_START_BIT];

    always_comb begin
        case (awaddr)
            axil_regs_pkg::REG_CTRL,
            axil_regs_pkg::REG_STATUS,
            axil_regs_pkg::REG_OPERAND_A,
            axil_regs_pkg::REG_OPERAND_B,
            axil_regs_pkg::REG_RESULT:    wr_resp = axil_regs_pkg::RESP_OKAY;
            default:                      wr_resp = axil_regs_pkg::RESP_SLVERR;
        endcase
    end

    always_comb begin
        rd_data = '0;
        rd_resp = axil_regs_pkg::RESP_OKAY;
        case (araddr)
            axil_regs_pkg::REG_CTRL: begin
                rd_data = '0;
            end
            axil_regs_pkg::REG_STATUS: begin
                rd_data[axil_regs_pkg::STATUS_BUSY_BIT] = !done;
                rd_data[axil_regs_pkg::STATUS_DONE_BIT] = done_sticky;
            end
            axil_regs_pkg::REG_OPERAND_A: begin
                rd_data = {{EXT{a.raw[fxp_pkg::NUMBER_WIDTH-1]}}, a.raw};
            end
            axil_regs_pkg::REG_OPERAND_B: begin
                rd_data = {{EXT{b.raw[fxp_pkg::NUMBER_WIDTH-1]}}, b.raw};
            end
            axil_regs_pkg::REG_RESULT: begin
                rd_data = {{EXT{result.raw[fxp_pkg::NUMBER_WIDTH-1]}}, result.raw};
            end
            default: begin
                rd_resp = axil_regs_pkg::RESP_SLVERR;
            end
        endcase
    end

    // Write address and data are taken together, one word per response.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= !awready && awvalid && wvalid && !bvalid;
            wready  <= !wready && awvalid && wvalid && !bvalid;
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_resp;
        end
        if (wr_accept && awaddr == axil_regs_pkg::REG_OPERAND_A) begin
            a.raw <= wdata[fxp_pkg::NUMBER_WIDTH-1:0];
        end
        if (wr_accept && awaddr == axil_regs_pkg::REG_OPERAND_B) begin
            b.raw <= wdata[fxp_pkg::NUMBER_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    // Start is dropped while the engine is busy.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start       <= 1'b0;
            done_prev   <= 1'b1;
            done_sticky <= 1'b0;
        end else begin
            start     <= start_write && done;
            done_prev <= done;
            if (start_write) begin
                done_sticky <= 1'b0;
            end else if (done && !done_prev) begin
                done_sticky <= 1'b1;
            end
        end
    end

endmodule

//--- pow_unit_top.sv
////////////////////////////////////////////////////////////
// Power unit: AXI4-Lite register block driving the
// fixed-point power engine.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pow_unit_top #(
    parameter int BITS_PER_CYCLE = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [axil_regs_pkg::ADDR_WIDTH-1:0]   awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [axil_regs_pkg::DATA_WIDTH-1:0]   wdata,
    input  logic [axil_regs_pkg::DATA_WIDTH/8-1:0] wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    output logic [1:0]                             bresp,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  logic [axil_regs_pkg::ADDR_WIDTH-1:0]   araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic [axil_regs_pkg::DATA_WIDTH-1:0]   rdata,
    output logic [1:0]                             rresp,
    output logic                                   rvalid,
    input  logic                                   rready
);

    logic               eng_start;
    logic               eng_done;
    fxp_pkg::fxp_word_t eng_a;
    fxp_pkg::fxp_word_t eng_b;
    fxp_pkg::fxp_word_t eng_result;

    pow_axil_regs regs0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .start   (eng_start),
        .a       (eng_a),
        .b       (eng_b),
        .done    (eng_done),
        .result  (eng_result)
    );

    fixed_point_pow #(
        .BITS_PER_CYCLE (BITS_PER_CYCLE)
    ) pow0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (eng_start),
        .done   (eng_done),
        .a      (eng_a),
        .b      (eng_b),
        .result (eng_result)
    );

endmodule

//--- pow_unit_assert.sv
////////////////////////////////////////////////////////////
// Protocol assertions for the power unit, bound into the
// top level.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pow_unit_assert (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic                                 bvalid,
    input logic                                 bready,
    input logic [1:0]                           bresp,
    input logic                                 rvalid,
    input logic                                 rready,
    input logic [axil_regs_pkg::DATA_WIDTH-1:0] rdata,
    input logic                                 eng_start,
    input logic                                 eng_done
);

    // Responses stay put until the master takes them.
    bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("Write response changed before bready");

    rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("Read response changed before rready");

    start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        eng_start |-> eng_done)
        else $error("Engine started while busy");

    idle_after_reset: assert property (@(posedge clk) !rst_n |=> eng_done)
        else $error("Engine not idle after reset");

endmodule

bind pow_unit_top pow_unit_assert assert0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .eng_start (eng_start),
    .eng_done  (eng_done)
);

//--- tb_pow_unit.sv
////////////////////////////////////////////////////////////
// Testbench for the power unit. Runs AXI4-Lite transactions
// and checks results against the vectors in pow_tests.txt.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_pow_unit;

    localparam int AW        = axil_regs_pkg::ADDR_WIDTH;
    localparam int DW        = axil_regs_pkg::DATA_WIDTH;
    localparam int MAX_TESTS = 64;
    localparam logic [47:0] NO_ENTRY = '1;
    localparam logic [AW-1:0] UNMAPPED_RD = 5'h14;
    localparam logic [AW-1:0] UNMAPPED_WR = 5'h18;

    logic            clk;
    logic            rst_n;
    logic [AW-1:0]   awaddr;
    logic            awvalid;
    logic            awready;
    logic [DW-1:0]   wdata;
    logic [DW/8-1:0] wstrb;
    logic            wvalid;
    logic            wready;
    logic [1:0]      bresp;
    logic            bvalid;
    logic            bready;
    logic [AW-1:0]   araddr;
    logic            arvalid;
    logic            arready;
    logic [DW-1:0]   rdata;
    logic [1:0]      rresp;
    logic            rvalid;
    logic            rready;

    // Each entry is A, B and the expected result, 16 bits each.
    logic [47:0] tests [0:MAX_TESTS-1];
    int          num_tests;
    bit          tests_loaded;
    int          errors;
    int          seed;

    pow_unit_top #(
        .BITS_PER_CYCLE (2)
    ) dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #10 clk = ~clk;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic axi_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                             output logic [1:0] resp);
        int stall;
        stall   = $unsigned($random(seed)) % 4;
        awaddr  = addr;
        wdata   = data;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(negedge clk); while (!(awready && wready));
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (stall) next_cycle();
        bready = 1'b1;
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        next_cycle();
        bready = 1'b0;
        // One response per write.
        check("bvalid", 32'(bvalid), 32'h0);
    endtask

    task automatic axi_read(input logic [AW-1:0] addr, output logic [DW-1:0] data,
                            output logic [1:0] resp);
        int stall;
        stall   = $unsigned($random(seed)) % 4;
        araddr  = addr;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        next_cycle();
        arvalid = 1'b0;
        repeat (stall) next_cycle();
        rready = 1'b1;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        next_cycle();
        rready = 1'b0;
        check("rvalid", 32'(rvalid), 32'h0);
    endtask

    task automatic write_reg(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check("bresp", 32'(resp), 32'(axil_regs_pkg::RESP_OKAY));
    endtask

    task automatic read_reg(input logic [AW-1:0] addr, output logic [DW-1:0] data);
        logic [1:0] resp;
        axi_read(addr, data, resp);
        check("rresp", 32'(resp), 32'(axil_regs_pkg::RESP_OKAY));
    endtask

    // Poll STATUS until the sticky done bit is set.
    task automatic wait_done();
        logic [DW-1:0] status;
        status = '0;
        while (!status[axil_regs_pkg::STATUS_DONE_BIT]) begin
            read_reg(axil_regs_pkg::REG_STATUS, status);
        end
        check("rdata STATUS", status, 32'(1) << axil_regs_pkg::STATUS_DONE_BIT);
    endtask

    task automatic run_power(input logic [15:0] a_val, input logic [15:0] b_val,
                             input logic [15:0] expected);
        logic [DW-1:0] res;
        write_reg(axil_regs_pkg::REG_OPERAND_A, {16'h0, a_val});
        write_reg(axil_regs_pkg::REG_OPERAND_B, {16'h0, b_val});
        write_reg(axil_regs_pkg::REG_CTRL, 32'h1);
        wait_done();
        read_reg(axil_regs_pkg::REG_RESULT, res);
        check("rdata RESULT", res, {{16{expected[15]}}, expected});
    endtask

    initial begin
        wait (tests_loaded);
        repeat (num_tests * 3000 + 1000) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles",
                 num_tests * 3000 + 1000);
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [DW-1:0] rd_value;
        logic [1:0]    resp;
        int            idx;
        seed         = 98;
        errors       = 0;
        num_tests    = 0;
        tests_loaded = 1'b0;
        clk          = 1'b0;
        rst_n        = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;

        for (idx = 0; idx < MAX_TESTS; idx++) begin
            tests[idx] = NO_ENTRY;
        end
        $readmemh("pow_tests.txt", tests);
        while (num_tests < MAX_TESTS && tests[num_tests] != NO_ENTRY) begin
            num_tests++;
        end
        tests_loaded = 1'b1;
        if (num_tests == 0) begin
            $display("No test vectors were found in pow_tests.txt");
            errors++;
        end

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Register readback and error responses.
        read_reg(axil_regs_pkg::REG_STATUS, rd_value);
        check("rdata STATUS", rd_value, 32'h0);
        write_reg(axil_regs_pkg::REG_OPERAND_A, 32'h0000_8123);
        write_reg(axil_regs_pkg::REG_OPERAND_B, 32'h0000_7F40);
        read_reg(axil_regs_pkg::REG_OPERAND_A, rd_value);
        check("rdata OPERAND_A", rd_value, 32'hFFFF_8123);
        read_reg(axil_regs_pkg::REG_OPERAND_B, rd_value);
        check("rdata OPERAND_B", rd_value, 32'h0000_7F40);
        write_reg(axil_regs_pkg::REG_RESULT, 32'h0000_1234);
        read_reg(axil_regs_pkg::REG_RESULT, rd_value);
        check("rdata RESULT", rd_value, 32'h0);
        axi_read(UNMAPPED_RD, rd_value, resp);
        check("rresp", 32'(resp), 32'(axil_regs_pkg::RESP_SLVERR));
        axi_write(UNMAPPED_WR, 32'h1, resp);
        check("bresp", 32'(resp), 32'(axil_regs_pkg::RESP_SLVERR));

        for (idx = 0; idx < num_tests; idx++) begin
            run_power(tests[idx][47:32], tests[idx][31:16], tests[idx][15:0]);
        end

        // 1.0 to the 255th keeps the engine busy for a while.
        write_reg(axil_regs_pkg::REG_OPERAND_A, 32'(fxp_pkg::FXP_ONE));
        write_reg(axil_regs_pkg::REG_OPERAND_B, 32'h0000_FF00);
        write_reg(axil_regs_pkg::REG_CTRL, 32'h1);
        read_reg(axil_regs_pkg::REG_STATUS, rd_value);
        check("rdata STATUS", rd_value, 32'(1) << axil_regs_pkg::STATUS_BUSY_BIT);
        write_reg(axil_regs_pkg::REG_OPERAND_A, 32'h0000_0200);
        write_reg(axil_regs_pkg::REG_OPERAND_B, 32'h0000_0100);
        write_reg(axil_regs_pkg::REG_CTRL, 32'h1);
        wait_done();
        read_reg(axil_regs_pkg::REG_RESULT, rd_value);
        check("rdata RESULT", rd_value, 32'(fxp_pkg::FXP_ONE));
        // The new operands only count after a fresh start.
        write_reg(axil_regs_pkg::REG_CTRL, 32'h1);
        wait_done();
        read_reg(axil_regs_pkg::REG_RESULT, rd_value);
        check("rdata RESULT", rd_value, 32'h0000_0200);

        $display("Ran %0d file tests, %0d errors", num_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- pow_tests.txt
// Columns: A (4 hex digits), B (4 hex digits), expected result (4 hex digits)
// All values are signed 8.8 fixed point, packed into one 48-bit word.
018000000100
018000FF0100
018001000180
020003000800
020003FF0800
018002000240
018003000360
FF000300FF00
FE000300F800
008003000020
008008000001
008009000000
0C0002009000
0A000300E800
FF800300FFE0
FE800300FCA0
010104000104
0100FF000100
FF010300FF02
000000000100

//--- verilog.f
fxp_pkg.sv
axil_regs_pkg.sv
fixed_point_mul.sv
fixed_point_pow.sv
pow_axil_regs.sv
pow_unit_top.sv
pow_unit_assert.sv
tb_pow_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the power unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pow_unit -f verilog.f

out=$(./obj_dir/Vtb_pow_unit 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1
